//--- soc_fabric.f
logic/soc_pkg.sv
logic/bus_arbiter.sv
logic/addr_decoder.sv
logic/sram_slave.sv
logic/gpio_port.sv
logic/reset_ctrl.sv
logic/soc_fabric.sv
tests/clk_gen.sv
tests/soc_fabric_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the fabric testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f soc_fabric.f --top-module soc_fabric_tb -o soc_fabric_sim

# A failing run exits non-zero, the log decides the result
./obj_dir/soc_fabric_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  echo "Simulation failed"
  exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation passed"

//--- tests/soc_fabric_tb.sv
`timescale 1ns/1ps
`default_nettype none

module soc_fabric_tb
  import soc_pkg::*;
;

  logic  sys_clk, rst_i;
  logic  m0_cyc_i, m0_stb_i, m0_we_i, m1_cyc_i, m1_stb_i, m1_we_i;
  adr_t  m0_adr_i, m1_adr_i;
  sel_t  m0_sel_i, m1_sel_i;
  dat_t  m0_dat_i, m1_dat_i, m0_dat_o, m1_dat_o;
  logic  m0_stall_o, m0_ack_o, m0_err_o, m1_stall_o, m1_ack_o, m1_err_o;
  gpio_t gpio_i, gpio_o;
  logic  por_done_o;

  // Per-master views of the responses
  logic stall_w [2];
  logic ack_w [2];
  logic err_w [2];
  dat_t rdat_w [2];

  // Expected responses as {check data, err, data}
  logic [33:0] exp_q [2][$];
  int          issue_cnt [2];
  int          resp_cnt [2];
  dat_t        last_rdat [2];
  logic [33:0] ent;

  // Reference state
  dat_t       ram_model [RAM_WORDS];
  gpio_t      gpio_out_model;
  gpio_t      gpio_pin_model;
  logic [1:0] reason_model;

  integer seed = 32'h2238;
  string  cur_test = "init";
  int     cycles;
  dat_t   saved;

  assign stall_w[0] = m0_stall_o;
  assign stall_w[1] = m1_stall_o;
  assign ack_w[0]   = m0_ack_o;
  assign ack_w[1]   = m1_ack_o;
  assign err_w[0]   = m0_err_o;
  assign err_w[1]   = m1_err_o;
  assign rdat_w[0]  = m0_dat_o;
  assign rdat_w[1]  = m1_dat_o;

  clk_gen clk_gen_i (.sys_clk_o(sys_clk), .rst_o(rst_i));

  soc_fabric soc_fabric_i (.*);

  task automatic stop_with_error(string msg);
    $display("ERROR: %s (test %s)", msg, cur_test);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
      $display("TESTBENCH FAILED");
      $fatal(1);
    end
  endtask

  // Expected {err, data} of a read from the address map
  function automatic logic [32:0] ref_read(adr_t adr);
    if (adr - RAM_BASE < RAM_SIZE) begin
      return {1'b0, ram_model[adr[RAM_AW+1:2]]};
    end else if (adr >= GPIO_BASE && adr - GPIO_BASE < GPIO_SIZE) begin
      if (adr[3:2] == 2'd0) return {1'b0, 24'd0, gpio_out_model};
      if (adr[3:2] == 2'd1) return {1'b0, 24'd0, gpio_pin_model};
      return 33'd0;
    end else if (adr >= RSTCTRL_BASE && adr - RSTCTRL_BASE < RSTCTRL_SIZE) begin
      return adr[2] ? {1'b0, 30'd0, reason_model} : 33'd0;
    end
    return {1'b1, 32'd0};  // Unmapped
  endfunction

  function automatic void apply_write(adr_t adr, sel_t sel, dat_t dat);
    if (adr - RAM_BASE < RAM_SIZE) begin
      for (int i = 0; i < 4; i++) begin
        if (sel[i]) ram_model[adr[RAM_AW+1:2]][8*i +: 8] = dat[8*i +: 8];
      end
    end else if (adr >= GPIO_BASE && adr - GPIO_BASE < GPIO_SIZE) begin
      if (adr[3:2] == 2'd0 && sel[0]) gpio_out_model = dat[7:0];
    end else if (adr >= RSTCTRL_BASE && adr - RSTCTRL_BASE < RSTCTRL_SIZE) begin
      if (!adr[2] && dat[0]) begin
        reason_model   = 2'b10;
        gpio_out_model = '0;  // Cleared by the peripheral reset
      end
    end
  endfunction

  task automatic drive(int m, logic cyc, logic stb, logic we, adr_t adr, sel_t sel, dat_t dat);
    if (m == 0) begin
      m0_cyc_i = cyc;
      m0_stb_i = stb;
      m0_we_i  = we;
      m0_adr_i = adr;
      m0_sel_i = sel;
      m0_dat_i = dat;
    end else begin
      m1_cyc_i = cyc;
      m1_stb_i = stb;
      m1_we_i  = we;
      m1_adr_i = adr;
      m1_sel_i = sel;
      m1_dat_i = dat;
    end
  endtask

  // Called right after a falling edge and returns before the rising edge that accepts
  task automatic wait_accept(int m);
    int t;
    t = 0;
    #1;
    while (stall_w[m]) begin
      t++;
      if (t > 300) stop_with_error("master never granted the bus");
      @(negedge sys_clk);
      #1;
    end
  endtask

  task automatic record(int m, logic we, adr_t adr, sel_t sel, dat_t dat, logic chk);
    logic [32:0] r;
    r = ref_read(adr);
    if (we) begin
      exp_q[m].push_back({1'b0, r[32], 32'd0});
      if (!r[32]) apply_write(adr, sel, dat);
    end else begin
      exp_q[m].push_back({chk, r});
    end
    issue_cnt[m]++;
  endtask

  task automatic wait_responses(int m);
    int t;
    t = 0;
    while (resp_cnt[m] != issue_cnt[m]) begin
      t++;
      if (t > 50) stop_with_error("response missing");
      @(negedge sys_clk);
    end
  endtask

  task automatic single(int m, logic we, adr_t adr, sel_t sel, dat_t dat, logic chk);
    @(negedge sys_clk);
    drive(m, 1'b1, 1'b1, we, adr, sel, dat);
    wait_accept(m);
    record(m, we, adr, sel, dat, chk);
    @(negedge sys_clk);
    drive(m, 1'b0, 1'b0, 1'b0, '0, '0, '0);
    wait_responses(m);
  endtask

  // Back-to-back RAM traffic on 16 words starting at base
  task automatic burst(int m, int base, int n);
    logic we;
    adr_t adr;
    sel_t sel;
    dat_t dat;
    for (int i = 0; i < 16 + n; i++) begin
      if (i < 16) begin
        we  = 1'b1;  // Fill the words first
        adr = 32'((base + i) * 4);
        sel = 4'hF;
      end else begin
        we  = 1'($random(seed));
        adr = 32'((base + ($unsigned($random(seed)) % 16)) * 4);
        sel = 4'($random(seed));
      end
      dat = $random(seed);
      @(negedge sys_clk);
      drive(m, 1'b1, 1'b1, we, adr, sel, dat);
      wait_accept(m);
      record(m, we, adr, sel, dat, 1'b1);
    end
    @(negedge sys_clk);
    drive(m, 1'b0, 1'b0, 1'b0, '0, '0, '0);
    wait_responses(m);
  endtask

  // Compare process
  always @(negedge sys_clk) begin
    #1;
    for (int m = 0; m < 2; m++) begin
      if (!rst_i && (ack_w[m] === 1'b1 || err_w[m] === 1'b1)) begin
        if (exp_q[m].size() == 0) stop_with_error("response without a request");
        ent = exp_q[m].pop_front();
        check_value({cur_test, " err"}, 32'(ent[32]), 32'(err_w[m]));
        check_value({cur_test, " ack"}, 32'(!ent[32]), 32'(ack_w[m]));
        if (ent[33]) check_value({cur_test, " data"}, ent[31:0], rdat_w[m]);
        last_rdat[m] = rdat_w[m];
        resp_cnt[m]++;
      end
    end
  end

  initial begin
    drive(0, 1'b1, 1'b1, 1'b0, 32'h2000_0000, 4'hF, '0);  // Held until the bus opens
    drive(1, 1'b0, 1'b0, 1'b0, '0, '0, '0);
    gpio_i         = '0;
    gpio_out_model = '0;
    gpio_pin_model = '0;
    reason_model   = 2'b01;
    issue_cnt      = '{0, 0};
    resp_cnt       = '{0, 0};

    cur_test = "por_delay";
    cycles = 0;
    do begin
      @(negedge sys_clk);
      #1;
      cycles++;
      if (cycles > 50) stop_with_error("reset never released");
    end while (rst_i);
    cycles = 0;
    do begin
      @(negedge sys_clk);
      #1;
      cycles++;
      if (cycles > 100) stop_with_error("power-on delay never ended");
      if (!por_done_o) begin
        check_value("por_stall_m0", 32'd1, 32'(m0_stall_o));
        check_value("por_stall_m1", 32'd1, 32'(m1_stall_o));
      end
    end while (!por_done_o);
    check_value(cur_test, 32'(POR_CYCLES), 32'(cycles));
    check_value("por_stall", 32'd0, 32'(m0_stall_o));
    record(0, 1'b0, 32'h2000_0000, 4'hF, '0, 1'b1);  // Accepted on the next rising edge
    @(negedge sys_clk);
    drive(0, 1'b0, 1'b0, 1'b0, '0, '0, '0);
    wait_responses(0);

    cur_test = "ram_access";
    burst(0, 0, 40);

    cur_test = "arbitration";
    fork
      burst(0, 16, 40);
      burst(1, 64, 40);
    join

    cur_test = "unmapped";
    saved = ram_model[5];
    single(0, 1'b1, 32'h2000_0014, 4'hF, 32'hDEAD_BEEF, 1'b0);
    single(1, 1'b0, 32'h1000_0040, 4'hF, '0, 1'b1);
    single(0, 1'b0, 32'h0000_0014, 4'hF, '0, 1'b1);
    check_value(cur_test, saved, last_rdat[0]);

    cur_test = "gpio";
    single(0, 1'b1, GPIO_BASE, 4'h1, 32'h0000_00A5, 1'b0);
    check_value("gpio_out", 32'h0000_00A5, 32'(gpio_o));
    gpio_i = 8'h3C;
    cycles = 0;
    do begin
      single(0, 1'b0, GPIO_BASE + 4, 4'hF, '0, 1'b0);  // Unchecked until settled
      cycles++;
      if (cycles > 20) stop_with_error("GPIO input never settled");
    end while (last_rdat[0] != 32'h0000_003C);
    gpio_pin_model = 8'h3C;
    single(0, 1'b0, GPIO_BASE + 4, 4'hF, '0, 1'b1);

    cur_test = "soft_reset";
    single(0, 1'b0, RSTCTRL_BASE + 4, 4'hF, '0, 1'b1);
    single(0, 1'b1, RSTCTRL_BASE, 4'hF, 32'd1, 1'b0);
    cycles = 0;
    while (soc_fabric_i.periph_rst !== 1'b1) begin
      @(negedge sys_clk);
      cycles++;
      if (cycles > 20) stop_with_error("soft reset never started");
    end
    cycles = 0;
    while (soc_fabric_i.periph_rst !== 1'b0) begin
      @(negedge sys_clk);
      cycles++;
      if (cycles > 40) stop_with_error("soft reset never ended");
    end
    check_value("gpio_cleared", 32'd0, 32'(gpio_o));
    single(0, 1'b0, RSTCTRL_BASE + 4, 4'hF, '0, 1'b1);
    for (int w = 0; w < 16; w++) begin
      single(w % 2, 1'b0, 32'(w * 4), 4'hF, '0, 1'b1);  // RAM kept
    end

    @(negedge sys_clk);
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- tests/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
  output logic sys_clk_o,
  output logic rst_o
);

  initial begin
    sys_clk_o = 1'b0;
    forever #2 sys_clk_o = ~sys_clk_o;  // 4 ns period
  end

  // Reset held for 8 cycles and released on a falling edge
  initial begin
    rst_o = 1'b1;
    repeat (8) @(posedge sys_clk_o);
    @(negedge sys_clk_o);
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire

//--- logic/soc_fabric.sv
`timescale 1ns/1ps
`default_nettype none

module soc_fabric
  import soc_pkg::*;
(
  input  logic  sys_clk,
  input  logic  rst_i,
  // Master 0
  input  logic  m0_cyc_i,
  input  logic  m0_stb_i,
  input  logic  m0_we_i,
  input  adr_t  m0_adr_i,
  input  sel_t  m0_sel_i,
  input  dat_t  m0_dat_i,
  output logic  m0_stall_o,
  output logic  m0_ack_o,
  output logic  m0_err_o,
  output dat_t  m0_dat_o,
  // Master 1
  input  logic  m1_cyc_i,
  input  logic  m1_stb_i,
  input  logic  m1_we_i,
  input  adr_t  m1_adr_i,
  input  sel_t  m1_sel_i,
  input  dat_t  m1_dat_i,
  output logic  m1_stall_o,
  output logic  m1_ack_o,
  output logic  m1_err_o,
  output dat_t  m1_dat_o,
  // GPIO pins
  input  gpio_t gpio_i,
  output gpio_t gpio_o,
  output logic  por_done_o
);

  // Shared bus
  logic bus_cyc, bus_stb, bus_we, bus_ack, bus_err;
  adr_t bus_adr;
  sel_t bus_sel;
  dat_t bus_wdat, bus_rdat;

  // Slave side
  logic ram_stb, gpio_stb, rst_stb;
  logic ram_ack, gpio_ack, rst_ack;
  dat_t ram_rdat, gpio_rdat, rst_rdat;

  logic por_done;
  logic periph_rst;

  assign por_done_o = por_done;

  bus_arbiter bus_arbiter_i (
    .sys_clk      (sys_clk),
    .rst_i        (rst_i),
    .periph_rst_i (periph_rst),
    .por_done_i   (por_done),
    .m0_cyc_i, .m0_stb_i, .m0_we_i, .m0_adr_i, .m0_sel_i, .m0_dat_i,
    .m0_stall_o, .m0_ack_o, .m0_err_o, .m0_dat_o,
    .m1_cyc_i, .m1_stb_i, .m1_we_i, .m1_adr_i, .m1_sel_i, .m1_dat_i,
    .m1_stall_o, .m1_ack_o, .m1_err_o, .m1_dat_o,
    .bus_cyc_o    (bus_cyc),
    .bus_stb_o    (bus_stb),
    .bus_we_o     (bus_we),
    .bus_adr_o    (bus_adr),
    .bus_sel_o    (bus_sel),
    .bus_wdat_o   (bus_wdat),
    .bus_ack_i    (bus_ack),
    .bus_err_i    (bus_err),
    .bus_rdat_i   (bus_rdat)
  );

  addr_decoder addr_decoder_i (
    .sys_clk     (sys_clk),
    .rst_i       (rst_i),
    .bus_cyc_i   (bus_cyc),
    .bus_stb_i   (bus_stb),
    .bus_adr_i   (bus_adr),
    .bus_ack_o   (bus_ack),
    .bus_err_o   (bus_err),
    .bus_rdat_o  (bus_rdat),
    .ram_stb_o   (ram_stb),
    .gpio_stb_o  (gpio_stb),
    .rst_stb_o   (rst_stb),
    .ram_ack_i   (ram_ack),
    .gpio_ack_i  (gpio_ack),
    .rst_ack_i   (rst_ack),
    .ram_rdat_i  (ram_rdat),
    .gpio_rdat_i (gpio_rdat),
    .rst_rdat_i  (rst_rdat)
  );

  sram_slave sram_slave_i (
    .sys_clk (sys_clk),
    .stb_i   (ram_stb),
    .we_i    (bus_we),
    .adr_i   (bus_adr),
    .sel_i   (bus_sel),
    .dat_i   (bus_wdat),
    .ack_o   (ram_ack),
    .rdat_o  (ram_rdat)
  );

  gpio_port gpio_port_i (
    .sys_clk      (sys_clk),
    .rst_i        (rst_i),
    .periph_rst_i (periph_rst),
    .stb_i        (gpio_stb),
    .we_i         (bus_we),
    .adr_i        (bus_adr),
    .sel_i        (bus_sel),
    .dat_i        (bus_wdat),
    .ack_o        (gpio_ack),
    .rdat_o       (gpio_rdat),
    .gpio_i       (gpio_i),
    .gpio_o       (gpio_o)
  );

  // Reset controller only sees rst_i, so it survives its own soft reset
  reset_ctrl reset_ctrl_i (
    .sys_clk      (sys_clk),
    .rst_i        (rst_i),
    .stb_i        (rst_stb),
    .we_i         (bus_we),
    .adr_i        (bus_adr),
    .dat_i        (bus_wdat),
    .ack_o        (rst_ack),
    .rdat_o       (rst_rdat),
    .por_done_o   (por_done),
    .periph_rst_o (periph_rst)
  );

endmodule

`default_nettype wire

//--- logic/reset_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module reset_ctrl
  import soc_pkg::*;
(
  input  logic sys_clk,
  input  logic rst_i,
  input  logic stb_i,
  input  logic we_i,
  input  adr_t adr_i,
  input  dat_t dat_i,
  output logic ack_o,
  output dat_t rdat_o,
  output logic por_done_o,
  output logic periph_rst_o
);

  logic [$clog2(POR_CYCLES+1)-1:0]      por_cnt;
  logic [$clog2(SOFT_RST_CYCLES+1)-1:0] srst_cnt;
  logic [1:0]                           reason_q;  // Bit 1 soft, bit 0 power-on
  logic                                 trigger;

  assign trigger = stb_i && we_i && !adr_i[2] && dat_i[0];

  // Power-on delay before the bus opens
  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      por_cnt    <= '0;
      por_done_o <= 1'b0;
    end else if (!por_done_o) begin
      if (por_cnt == POR_CYCLES[$bits(por_cnt)-1:0] - 1'b1) begin
        por_done_o <= 1'b1;
      end
      por_cnt <= por_cnt + 1'b1;
    end
  end

  // Soft reset drives periph_rst_o from the cycle after the ack
  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      srst_cnt     <= '0;
      periph_rst_o <= 1'b1;
      reason_q     <= 2'b01;
    end else begin
      periph_rst_o <= srst_cnt != '0;
      if (trigger) begin
        srst_cnt <= SOFT_RST_CYCLES[$bits(srst_cnt)-1:0];
        reason_q <= 2'b10;
      end else if (srst_cnt != '0) begin
        srst_cnt <= srst_cnt - 1'b1;
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= stb_i;
    end
  end

  always_ff @(posedge sys_clk) begin
    if (stb_i) begin
      rdat_o <= adr_i[2] ? {{(DAT_W-2){1'b0}}, reason_q} : '0;  // Word 0 is write-only
    end
  end

endmodule

`default_nettype wire

//--- logic/gpio_port.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_port
  import soc_pkg::*;
(
  input  logic  sys_clk,
  input  logic  rst_i,
  input  logic  periph_rst_i,
  input  logic  stb_i,
  input  logic  we_i,
  input  adr_t  adr_i,
  input  sel_t  sel_i,
  input  dat_t  dat_i,
  output logic  ack_o,
  output dat_t  rdat_o,
  input  gpio_t gpio_i,
  output gpio_t gpio_o
);

  gpio_t      out_q;
  gpio_t      sync1_q;
  gpio_t      sync2_q;
  logic [1:0] word;

  assign word = adr_i[3:2];

  // Two-flop synchronizer for the pins
  always_ff @(posedge sys_clk) begin
    sync1_q <= gpio_i;
    sync2_q <= sync1_q;
  end

  always_ff @(posedge sys_clk) begin
    if (rst_i || periph_rst_i) begin
      out_q <= '0;
      ack_o <= 1'b0;
    end else begin
      ack_o <= stb_i;
      if (stb_i && we_i && word == 2'd0 && sel_i[0]) begin
        out_q <= dat_i[GPIO_W-1:0];
      end
    end
  end

  always_ff @(posedge sys_clk) begin
    if (stb_i) begin
      case (word)
        2'd0:    rdat_o <= {{(DAT_W-GPIO_W){1'b0}}, out_q};
        2'd1:    rdat_o <= {{(DAT_W-GPIO_W){1'b0}}, sync2_q};
        default: rdat_o <= '0;
      endcase
    end
  end

  assign gpio_o = out_q;

endmodule

`default_nettype wire

//--- logic/sram_slave.sv
`timescale 1ns/1ps
`default_nettype none

module sram_slave
  import soc_pkg::*;
(
  input  logic sys_clk,
  input  logic stb_i,
  input  logic we_i,
  input  adr_t adr_i,
  input  sel_t sel_i,
  input  dat_t dat_i,
  output logic ack_o,
  output dat_t rdat_o
);

  dat_t              mem [RAM_WORDS];
  logic [RAM_AW-1:0] widx;

  assign widx = adr_i[RAM_AW+1:2];  // Word index from the byte address

  // Contents are kept through any reset
  always_ff @(posedge sys_clk) begin
    ack_o <= stb_i;
    if (stb_i) begin
      if (we_i) begin
        for (int i = 0; i < SEL_W; i++) begin
          if (sel_i[i]) begin
            mem[widx][8*i +: 8] <= dat_i[8*i +: 8];  // Byte lane merge
          end
        end
      end else begin
        rdat_o <= mem[widx];
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/addr_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module addr_decoder
  import soc_pkg::*;
(
  input  logic sys_clk,
  input  logic rst_i,
  input  logic bus_cyc_i,
  input  logic bus_stb_i,
  input  adr_t bus_adr_i,
  output logic bus_ack_o,
  output logic bus_err_o,
  output dat_t bus_rdat_o,
  output logic ram_stb_o,
  output logic gpio_stb_o,
  output logic rst_stb_o,
  input  logic ram_ack_i,
  input  logic gpio_ack_i,
  input  logic rst_ack_i,
  input  dat_t ram_rdat_i,
  input  dat_t gpio_rdat_i,
  input  dat_t rst_rdat_i
);

  slave_e slv;
  slave_e slv_q;   // Slave of the access one cycle back
  logic   req;
  logic   err_q;

  function automatic logic in_range(adr_t adr, adr_t base, adr_t size);
    return (adr >= base) && ((adr - base) < size);
  endfunction

  always_comb begin
    if (in_range(bus_adr_i, RAM_BASE, RAM_SIZE)) begin
      slv = RAM_S;
    end else if (in_range(bus_adr_i, GPIO_BASE, GPIO_SIZE)) begin
      slv = GPIO_S;
    end else if (in_range(bus_adr_i, RSTCTRL_BASE, RSTCTRL_SIZE)) begin
      slv = RSTCTRL_S;
    end else begin
      slv = NONE_S;
    end
  end

  assign req        = bus_cyc_i & bus_stb_i;
  assign ram_stb_o  = req && slv == RAM_S;
  assign gpio_stb_o = req && slv == GPIO_S;
  assign rst_stb_o  = req && slv == RSTCTRL_S;

  always_ff @(posedge sys_clk) begin
    if (rst_i) begin
      slv_q <= NONE_S;
      err_q <= 1'b0;
    end else begin
      slv_q <= req ? slv : NONE_S;
      err_q <= req && slv == NONE_S;  // Unmapped so no slave sees it
    end
  end

  always_comb begin
    case (slv_q)
      RAM_S:     bus_rdat_o = ram_rdat_i;
      GPIO_S:    bus_rdat_o = gpio_rdat_i;
      RSTCTRL_S: bus_rdat_o = rst_rdat_i;
      default:   bus_rdat_o = '0;
    endcase
  end

  assign bus_ack_o = ram_ack_i | gpio_ack_i | rst_ack_i;
  assign bus_err_o = err_q;

endmodule

`default_nettype wire

//--- logic/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter
  import soc_pkg::*;
(
  input  logic sys_clk,
  input  logic rst_i,
  input  logic periph_rst_i,
  input  logic por_done_i,
  // Master 0
  input  logic m0_cyc_i,
  input  logic m0_stb_i,
  input  logic m0_we_i,
  input  adr_t m0_adr_i,
  input  sel_t m0_sel_i,
  input  dat_t m0_dat_i,
  output logic m0_stall_o,
  output logic m0_ack_o,
  output logic m0_err_o,
  output dat_t m0_dat_o,
  // Master 1
  input  logic m1_cyc_i,
  input  logic m1_stb_i,
  input  logic m1_we_i,
  input  adr_t m1_adr_i,
  input  sel_t m1_sel_i,
  input  dat_t m1_dat_i,
  output logic m1_stall_o,
  output logic m1_ack_o,
  output logic m1_err_o,
  output dat_t m1_dat_o,
  // Shared bus
  output logic bus_cyc_o,
  output logic bus_stb_o,
  output logic bus_we_o,
  output adr_t bus_adr_o,
  output sel_t bus_sel_o,
  output dat_t bus_wdat_o,
  input  logic bus_ack_i,
  input  logic bus_err_i,
  input  dat_t bus_rdat_i
);

  logic       gnt;        // 0 = m0, 1 = m1
  logic       last_q;     // Owner in the previous cycle
  logic [1:0] pend_q;     // Requests of the owner still waiting for a response
  logic       last_cyc;
  logic       other_cyc;
  logic       accept;
  logic       resp;

  assign last_cyc  = last_q ? m1_cyc_i : m0_cyc_i;
  assign other_cyc = last_q ? m0_cyc_i : m1_cyc_i;

  // Owner keeps the bus while its cycle or a response is still open
  always_comb begin
    if (!last_cyc && pend_q == 2'd0 && other_cyc) begin
      gnt = ~last_q;  // Round robin hand-over
    end else begin
      gnt = last_q;
    end
  end

  assign bus_cyc_o  = por_done_i & (gnt ? m1_cyc_i : m0_cyc_i);
  assign bus_stb_o  = bus_cyc_o & (gnt ? m1_stb_i : m0_stb_i);
  assign bus_we_o   = gnt ? m1_we_i  : m0_we_i;
  assign bus_adr_o  = gnt ? m1_adr_i : m0_adr_i;
  assign bus_sel_o  = gnt ? m1_sel_i : m0_sel_i;
  assign bus_wdat_o = gnt ? m1_dat_i : m0_dat_i;

  assign m0_stall_o = ~por_done_i | gnt;
  assign m1_stall_o = ~por_done_i | ~gnt;

  // Responses only reach the owner
  assign m0_ack_o = bus_ack_i & ~gnt;
  assign m1_ack_o = bus_ack_i & gnt;
  assign m0_err_o = bus_err_i & ~gnt;
  assign m1_err_o = bus_err_i & gnt;
  assign m0_dat_o = bus_rdat_i;
  assign m1_dat_o = bus_rdat_i;

  assign accept = bus_stb_o;  // Slaves never stall
  assign resp   = bus_ack_i | bus_err_i;

  always_ff @(posedge sys_clk) begin
    if (rst_i || periph_rst_i) begin
      last_q <= 1'b0;
      pend_q <= 2'd0;
    end else begin
      last_q <= gnt;
      if (accept && !resp) begin
        pend_q <= pend_q + 2'd1;
      end else if (!accept && resp && pend_q != 2'd0) begin
        pend_q <= pend_q - 2'd1;
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/soc_pkg.sv
`default_nettype none

package soc_pkg;

  // Bus widths
  localparam int ADR_W  = 32;
  localparam int DAT_W  = 32;
  localparam int SEL_W  = DAT_W / 8;
  localparam int GPIO_W = 8;

  typedef logic [ADR_W-1:0]  adr_t;   // Byte address
  typedef logic [DAT_W-1:0]  dat_t;
  typedef logic [SEL_W-1:0]  sel_t;   // Byte lane enables
  typedef logic [GPIO_W-1:0] gpio_t;

  // Slave select with NONE_S for an unmapped access
  typedef enum logic [1:0] {
    RAM_S,
    GPIO_S,
    RSTCTRL_S,
    NONE_S
  } slave_e;

  // Address map with sizes in bytes
  localparam adr_t RAM_BASE     = 32'h0000_0000;
  localparam adr_t RAM_SIZE     = 32'h0000_1000;
  localparam adr_t GPIO_BASE    = 32'h1000_0000;
  localparam adr_t GPIO_SIZE    = 32'h0000_0010;
  localparam adr_t RSTCTRL_BASE = 32'h1000_0030;
  localparam adr_t RSTCTRL_SIZE = 32'h0000_0008;

  localparam int RAM_WORDS = 1024;
  localparam int RAM_AW    = 10;    // Word address bits

  // Reset sequencing in sys_clk cycles
  localparam int POR_CYCLES      = 16;
  localparam int SOFT_RST_CYCLES = 8;

endpackage

`default_nettype wire
